/* files.f */
hdl/net_pkg.sv
hdl/tx_pkg.sv
hdl/tx_ifs.sv
hdl/sync_queue.sv
hdl/tx_meta_arbiter.sv
hdl/tx_data_mux.sv
hdl/tx_stat_router.sv
hdl/tcp_tx_arbiter.sv
testbench/tb_tcp_tx_arbiter.sv

/* hdl/net_pkg.sv */
package net_pkg;

  // --------------------
  // Stream geometry
  // --------------------

  // Payload width of one beat
  localparam int data_bits = 64;

  // One enable bit per payload byte
  localparam int keep_bits = data_bits / 8;

  // Byte offset bits within a beat
  localparam int beat_log_bits = $clog2(keep_bits);

  // --------------------
  // Buffering
  // --------------------

  // Beats held per region before back-pressure
  localparam int data_fifo_depth = 16;

endpackage

/* hdl/sync_queue.sv */
`timescale 1ns/1ps

module sync_queue #(
  parameter int width = 8,
  parameter int depth = 8
) (
  input  logic             aclk,
  input  logic             aresetn,
  input  logic             val_snk,
  output logic             rdy_snk,
  input  logic [width-1:0] data_snk,
  output logic             val_src,
  input  logic             rdy_src,
  output logic [width-1:0] data_src
);

  localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_bits = $clog2(depth + 1);

  logic [width-1:0]    mem [depth];
  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0] count;
  logic                push;
  logic                pop;

  // Wrap at depth, works for any depth
  function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
    if (ptr == ptr_bits'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Flags from occupancy
  assign rdy_snk = (count != cnt_bits'(depth));
  assign val_src = (count != '0);
  assign push    = val_snk & rdy_snk;
  assign pop     = val_src & rdy_src;

  // Head shown without a register stage
  assign data_src = mem[rd_ptr];

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= data_snk;
    end
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Simultaneous push and pop keeps count
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* hdl/tcp_tx_arbiter.sv */
`timescale 1ns/1ps

module tcp_tx_arbiter (
  input  logic                            aclk,
  input  logic                            aresetn,

  // Requests from regions and toward the engine
  input  logic [tx_pkg::n_regions-1:0]    s_meta_valid,
  output logic [tx_pkg::n_regions-1:0]    s_meta_ready,
  input  tx_pkg::tx_meta_t                s_meta_data [tx_pkg::n_regions],
  output logic                            m_meta_valid,
  input  logic                            m_meta_ready,
  output tx_pkg::tx_meta_t                m_meta_data,

  // Payload from regions and toward the engine
  input  logic [tx_pkg::n_regions-1:0]    s_axis_tvalid,
  output logic [tx_pkg::n_regions-1:0]    s_axis_tready,
  input  logic [net_pkg::data_bits-1:0]   s_axis_tdata [tx_pkg::n_regions],
  input  logic [net_pkg::keep_bits-1:0]   s_axis_tkeep [tx_pkg::n_regions],
  input  logic [tx_pkg::n_regions-1:0]    s_axis_tlast,
  output logic                            m_axis_tvalid,
  input  logic                            m_axis_tready,
  output logic [net_pkg::data_bits-1:0]   m_axis_tdata,
  output logic [net_pkg::keep_bits-1:0]   m_axis_tkeep,
  output logic                            m_axis_tlast,

  // Status from the engine back to regions
  input  logic                            s_stat_valid,
  output logic                            s_stat_ready,
  input  tx_pkg::tx_stat_t                s_stat_data,
  output logic [tx_pkg::n_regions-1:0]    m_stat_valid,
  input  logic [tx_pkg::n_regions-1:0]    m_stat_ready,
  output tx_pkg::tx_stat_t                m_stat_data
);

  // Arbiter to payload mux
  seq_if seq_i ();

  // Arbiter to status router
  logic                           own_valid;
  logic                           own_ready;
  logic [tx_pkg::region_bits-1:0] own_region;

  tx_meta_arbiter u_arbiter (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .s_meta_valid (s_meta_valid),
    .s_meta_ready (s_meta_ready),
    .s_meta_data  (s_meta_data),
    .m_meta_valid (m_meta_valid),
    .m_meta_ready (m_meta_ready),
    .m_meta_data  (m_meta_data),
    .seq          (seq_i),
    .own_valid    (own_valid),
    .own_ready    (own_ready),
    .own_region   (own_region)
  );

  tx_data_mux u_data_mux (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .seq           (seq_i),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tkeep  (s_axis_tkeep),
    .s_axis_tlast  (s_axis_tlast),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tkeep  (m_axis_tkeep),
    .m_axis_tlast  (m_axis_tlast)
  );

  tx_stat_router u_stat_router (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .own_valid    (own_valid),
    .own_ready    (own_ready),
    .own_region   (own_region),
    .s_stat_valid (s_stat_valid),
    .s_stat_ready (s_stat_ready),
    .s_stat_data  (s_stat_data),
    .m_stat_valid (m_stat_valid),
    .m_stat_ready (m_stat_ready),
    .m_stat_data  (m_stat_data)
  );

endmodule

/* hdl/tx_data_mux.sv */
`timescale 1ns/1ps

module tx_data_mux (
  input  logic                             aclk,
  input  logic                             aresetn,
  seq_if.snk                               seq,
  input  logic [tx_pkg::n_regions-1:0]     s_axis_tvalid,
  output logic [tx_pkg::n_regions-1:0]     s_axis_tready,
  input  logic [net_pkg::data_bits-1:0]    s_axis_tdata [tx_pkg::n_regions],
  input  logic [net_pkg::keep_bits-1:0]    s_axis_tkeep [tx_pkg::n_regions],
  input  logic [tx_pkg::n_regions-1:0]     s_axis_tlast,
  output logic                             m_axis_tvalid,
  input  logic                             m_axis_tready,
  output logic [net_pkg::data_bits-1:0]    m_axis_tdata,
  output logic [net_pkg::keep_bits-1:0]    m_axis_tkeep,
  output logic                             m_axis_tlast
);

  logic [tx_pkg::region_bits+tx_pkg::beat_cnt_bits-1:0] rec_in;
  logic [tx_pkg::region_bits+tx_pkg::beat_cnt_bits-1:0] rec_head;
  logic                             head_valid;
  logic                             head_ready;
  logic                             rec_pop;
  logic [tx_pkg::region_bits-1:0]   head_region;
  logic [tx_pkg::beat_cnt_bits-1:0] head_beats;

  tx_pkg::mux_state_t               state;
  tx_pkg::mux_state_t               state_nxt;
  logic [tx_pkg::region_bits-1:0]   cur_region;
  logic [tx_pkg::beat_cnt_bits-1:0] cur_beats;
  logic [tx_pkg::beat_cnt_bits-1:0] cnt;
  logic                             busy;
  logic                             beat_fire;
  logic                             last_beat;

  logic [tx_pkg::n_regions-1:0]     buf_valid;
  logic [net_pkg::data_bits-1:0]    buf_tdata [tx_pkg::n_regions];
  logic [net_pkg::keep_bits-1:0]    buf_tkeep [tx_pkg::n_regions];
  logic [tx_pkg::n_regions-1:0]     buf_tlast;

  axis_if buf_axis [tx_pkg::n_regions] ();

  // --------------------
  // Ownership records
  // --------------------

  assign rec_in = {seq.region, seq.n_beats};

  sync_queue #(
    .width($bits(rec_in)),
    .depth(tx_pkg::n_outstanding)
  ) u_seq_queue (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .val_snk  (seq.valid),
    .rdy_snk  (seq.ready),
    .data_snk (rec_in),
    .val_src  (head_valid),
    .rdy_src  (head_ready),
    .data_src (rec_head)
  );

  assign {head_region, head_beats} = rec_head;

  // --------------------
  // Region buffers
  // --------------------

  for (genvar i = 0; i < tx_pkg::n_regions; i++) begin : g_buf
    logic [net_pkg::data_bits+net_pkg::keep_bits:0] buf_in;
    logic [net_pkg::data_bits+net_pkg::keep_bits:0] buf_out;

    // Last, keep and data packed into one word
    assign buf_in = {s_axis_tlast[i], s_axis_tkeep[i], s_axis_tdata[i]};

    sync_queue #(
      .width($bits(buf_in)),
      .depth(net_pkg::data_fifo_depth)
    ) u_buf (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .val_snk  (s_axis_tvalid[i]),
      .rdy_snk  (s_axis_tready[i]),
      .data_snk (buf_in),
      .val_src  (buf_axis[i].tvalid),
      .rdy_src  (buf_axis[i].tready),
      .data_src (buf_out)
    );

    assign {buf_axis[i].tlast, buf_axis[i].tkeep, buf_axis[i].tdata} = buf_out;

    // Drain only the owning region
    assign buf_axis[i].tready = busy && (cur_region == i) && m_axis_tready;

    // Flatten for the output select
    assign buf_valid[i] = buf_axis[i].tvalid;
    assign buf_tdata[i] = buf_axis[i].tdata;
    assign buf_tkeep[i] = buf_axis[i].tkeep;
    assign buf_tlast[i] = buf_axis[i].tlast;
  end

  // --------------------
  // Mux FSM
  // --------------------

  assign busy      = (state == tx_pkg::mux_busy);
  assign beat_fire = m_axis_tvalid & m_axis_tready;
  // Counter starts at one, so equal means final beat
  assign last_beat = beat_fire & (cnt == cur_beats);

  // Next record taken when idle or on the final beat
  assign head_ready = !busy || last_beat;
  assign rec_pop    = head_valid & head_ready;

  always_comb begin
    state_nxt = state;
    if (rec_pop) begin
      state_nxt = tx_pkg::mux_busy;
    end else if (last_beat) begin
      state_nxt = tx_pkg::mux_idle;
    end
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state      <= tx_pkg::mux_idle;
      cur_region <= '0;
      cur_beats  <= '0;
      cnt        <= '0;
    end else begin
      state <= state_nxt;
      if (rec_pop) begin
        cur_region <= head_region;
        cur_beats  <= head_beats;
        cnt        <= {{(tx_pkg::beat_cnt_bits-1){1'b0}}, 1'b1};
      end else if (beat_fire) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // Output beat straight from the selected buffer
  assign m_axis_tvalid = busy & buf_valid[cur_region];
  assign m_axis_tdata  = buf_tdata[cur_region];
  assign m_axis_tkeep  = buf_tkeep[cur_region];
  // Passed through only
  assign m_axis_tlast  = buf_tlast[cur_region];

endmodule

/* hdl/tx_ifs.sv */
`timescale 1ns/1ps

// --------------------
// Ownership record
// --------------------

// Region and beat count of one forwarded request
interface seq_if;
  logic                             valid;
  logic                             ready;
  logic [tx_pkg::region_bits-1:0]   region;
  logic [tx_pkg::beat_cnt_bits-1:0] n_beats;

  // Record producer
  modport src (
    output valid,
    input  ready,
    output region,
    output n_beats
  );

  // Record consumer
  modport snk (
    input  valid,
    output ready,
    input  region,
    input  n_beats
  );
endinterface

// --------------------
// Payload stream
// --------------------

interface axis_if;
  logic                           tvalid;
  logic                           tready;
  logic [net_pkg::data_bits-1:0]  tdata;
  logic [net_pkg::keep_bits-1:0]  tkeep;
  logic                           tlast;

  // Stream master
  modport m (
    output tvalid,
    input  tready,
    output tdata,
    output tkeep,
    output tlast
  );

  // Stream slave
  modport s (
    input  tvalid,
    output tready,
    input  tdata,
    input  tkeep,
    input  tlast
  );
endinterface

/* hdl/tx_meta_arbiter.sv */
`timescale 1ns/1ps

module tx_meta_arbiter (
  input  logic                             aclk,
  input  logic                             aresetn,
  input  logic [tx_pkg::n_regions-1:0]     s_meta_valid,
  output logic [tx_pkg::n_regions-1:0]     s_meta_ready,
  input  tx_pkg::tx_meta_t                 s_meta_data [tx_pkg::n_regions],
  output logic                             m_meta_valid,
  input  logic                             m_meta_ready,
  output tx_pkg::tx_meta_t                 m_meta_data,
  seq_if.src                               seq,
  output logic                             own_valid,
  input  logic                             own_ready,
  output logic [tx_pkg::region_bits-1:0]   own_region
);

  logic [tx_pkg::region_bits-1:0]   rr_ptr;
  logic [tx_pkg::region_bits-1:0]   grant_idx;
  logic [tx_pkg::region_bits-1:0]   scan_idx;
  logic                             grant_found;
  logic                             sinks_ready;
  logic                             accept;
  logic [tx_pkg::len_bits-1:0]      win_len;
  logic [tx_pkg::beat_cnt_bits-1:0] full_beats;
  logic                             partial_beat;

  // --------------------
  // Round-robin grant
  // --------------------

  // Scan from pointer, first requester wins
  always_comb begin
    grant_found = 1'b0;
    grant_idx   = rr_ptr;
    scan_idx    = rr_ptr;
    for (int k = 0; k < tx_pkg::n_regions; k++) begin
      scan_idx = rr_ptr + k[tx_pkg::region_bits-1:0];
      if (!grant_found && s_meta_valid[scan_idx]) begin
        grant_found = 1'b1;
        grant_idx   = scan_idx;
      end
    end
  end

  // Engine and both ownership queues must take it together
  assign sinks_ready = m_meta_ready & seq.ready & own_ready;
  assign accept      = grant_found & sinks_ready;

  // Only the winner sees ready
  always_comb begin
    s_meta_ready = '0;
    if (accept) begin
      s_meta_ready[grant_idx] = 1'b1;
    end
  end

  // Pointer moves past the winner
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      rr_ptr <= '0;
    end else if (accept) begin
      rr_ptr <= grant_idx + 1'b1;
    end
  end

  // --------------------
  // Forward and record
  // --------------------

  assign m_meta_valid = accept;
  assign m_meta_data  = s_meta_data[grant_idx];

  // Beats = ceil(len / 8), zero length not expected
  assign win_len      = m_meta_data.len;
  assign full_beats   = {1'b0, win_len[tx_pkg::len_bits-1:net_pkg::beat_log_bits]};
  assign partial_beat = |win_len[net_pkg::beat_log_bits-1:0];

  // Record for the payload mux
  assign seq.valid   = accept;
  assign seq.region  = grant_idx;
  assign seq.n_beats = full_beats + {{(tx_pkg::beat_cnt_bits-1){1'b0}}, partial_beat};

  // Record for the status router
  assign own_valid  = accept;
  assign own_region = grant_idx;

endmodule

/* hdl/tx_pkg.sv */
package tx_pkg;

  // --------------------
  // Regions
  // --------------------

  // Number of user regions sharing the engine
  localparam int n_regions = 4;
  // Region index width
  localparam int region_bits = 2;

  // --------------------
  // Request sizing
  // --------------------

  // Byte length field
  localparam int len_bits = 16;
  // Session id field
  localparam int sid_bits = 16;
  // Beat count width, one extra bit for the rounded-up count
  localparam int beat_cnt_bits = len_bits - net_pkg::beat_log_bits + 1;
  // Requests in flight per ownership queue
  localparam int n_outstanding = 8;

  // One transmit request
  typedef struct packed {
    logic [sid_bits-1:0] sid;
    logic [len_bits-1:0] len;
  } tx_meta_t;

  // One transmit status returned by the engine
  typedef struct packed {
    logic [sid_bits-1:0] sid;
    logic [len_bits-1:0] len;
    logic                err;
  } tx_stat_t;

  // Payload multiplexer FSM
  typedef enum logic {
    mux_idle,
    mux_busy
  } mux_state_t;

endpackage

/* hdl/tx_stat_router.sv */
`timescale 1ns/1ps

module tx_stat_router (
  input  logic                            aclk,
  input  logic                            aresetn,
  input  logic                            own_valid,
  output logic                            own_ready,
  input  logic [tx_pkg::region_bits-1:0]  own_region,
  input  logic                            s_stat_valid,
  output logic                            s_stat_ready,
  input  tx_pkg::tx_stat_t                s_stat_data,
  output logic [tx_pkg::n_regions-1:0]    m_stat_valid,
  input  logic [tx_pkg::n_regions-1:0]    m_stat_ready,
  output tx_pkg::tx_stat_t                m_stat_data
);

  logic                           head_valid;
  logic                           head_pop;
  logic [tx_pkg::region_bits-1:0] head_region;

  // Owners kept in request order
  sync_queue #(
    .width(tx_pkg::region_bits),
    .depth(tx_pkg::n_outstanding)
  ) u_own_queue (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .val_snk  (own_valid),
    .rdy_snk  (own_ready),
    .data_snk (own_region),
    .val_src  (head_valid),
    .rdy_src  (head_pop),
    .data_src (head_region)
  );

  // Valid only toward the head owner
  for (genvar i = 0; i < tx_pkg::n_regions; i++) begin : g_route
    assign m_stat_valid[i] = s_stat_valid && head_valid && (head_region == i);
  end

  // Status shared by all regions
  assign m_stat_data = s_stat_data;

  // Held low with no owner on record
  assign s_stat_ready = head_valid & m_stat_ready[head_region];
  assign head_pop     = s_stat_valid & s_stat_ready;

endmodule

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -Wno-fatal -f files.f --top-module tb_tcp_tx_arbiter -o sim_tb

# The log is judged below, not the exit status
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
  echo "simulation result: PASS"
else
  echo "simulation result: FAIL"
  exit 1
fi

/* testbench/tb_tcp_tx_arbiter.sv */
`timescale 1ns/1ps

module tb_tcp_tx_arbiter;

  localparam int clk_period = 8;
  localparam int n_tests    = 6;
  localparam int n_reg      = tx_pkg::n_regions;

  // One payload beat as the testbench sees it
  typedef struct packed {
    logic [net_pkg::data_bits-1:0] data;
    logic [net_pkg::keep_bits-1:0] keep;
    logic                          last;
  } beat_t;

  // Scoreboard entry per forwarded request
  typedef struct packed {
    logic [tx_pkg::region_bits-1:0] region;
    tx_pkg::tx_meta_t               meta;
  } rec_t;

  logic                          aclk;
  logic                          aresetn;
  logic [n_reg-1:0]              s_meta_valid;
  logic [n_reg-1:0]              s_meta_ready;
  tx_pkg::tx_meta_t              s_meta_data [n_reg];
  logic                          m_meta_valid;
  logic                          m_meta_ready;
  tx_pkg::tx_meta_t              m_meta_data;
  logic [n_reg-1:0]              s_axis_tvalid;
  logic [n_reg-1:0]              s_axis_tready;
  logic [net_pkg::data_bits-1:0] s_axis_tdata [n_reg];
  logic [net_pkg::keep_bits-1:0] s_axis_tkeep [n_reg];
  logic [n_reg-1:0]              s_axis_tlast;
  logic                          m_axis_tvalid;
  logic                          m_axis_tready;
  logic [net_pkg::data_bits-1:0] m_axis_tdata;
  logic [net_pkg::keep_bits-1:0] m_axis_tkeep;
  logic                          m_axis_tlast;
  logic                          s_stat_valid;
  logic                          s_stat_ready;
  tx_pkg::tx_stat_t              s_stat_data;
  logic [n_reg-1:0]              m_stat_valid;
  logic [n_reg-1:0]              m_stat_ready;
  tx_pkg::tx_stat_t              m_stat_data;

  // Stimulus still to be driven per region
  tx_pkg::tx_meta_t               req_q [n_reg][$];
  beat_t                          pay_q [n_reg][$];
  // Beats accepted into each region buffer
  beat_t                          sent_q [n_reg][$];
  // Requests seen at the engine for payload and status checks
  rec_t                           sb_q [$];
  rec_t                           own_q [$];
  logic [tx_pkg::region_bits-1:0] grant_log [$];
  tx_pkg::tx_meta_t               meta_log [$];

  int errors;
  int test_err0;
  int n_pass;
  int n_fail;
  int beats_due;
  int stats_seen;
  int cur_left;
  int cur_region;

  tcp_tx_arbiter dut_i (.*);

  // --------------------
  // Clock and watchdog
  // --------------------

  initial begin
    aclk = 1'b0;
    forever #(clk_period / 2) aclk = ~aclk;
  end

  // Generous bound per test
  initial begin
    repeat (n_tests * 2000) @(posedge aclk);
    $display("ERROR: watchdog expired after %0d cycles, a handshake never completed",
             n_tests * 2000);
    $display("test failed");
    $finish;
  end

  // --------------------
  // Reporting
  // --------------------

  task automatic flag_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  task automatic compare_meta(input string what, input tx_pkg::tx_meta_t got,
                              input tx_pkg::tx_meta_t exp);
    if (got !== exp) begin
      flag_mismatch($sformatf("%s sid %h len %0d, expected sid %h len %0d",
                              what, got.sid, got.len, exp.sid, exp.len));
    end
  endtask

  task automatic compare_beat(input string what,
                              input logic [net_pkg::data_bits-1:0] data,
                              input logic [net_pkg::keep_bits-1:0] keep,
                              input logic last, input beat_t exp);
    if (data !== exp.data || keep !== exp.keep || last !== exp.last) begin
      flag_mismatch($sformatf("%s %h/%b/%b, expected %h/%b/%b",
                              what, data, keep, last, exp.data, exp.keep, exp.last));
    end
  endtask

  // Region index travels with the word
  task automatic compare_stat(input string what, input int got_region,
                              input tx_pkg::tx_stat_t got, input int exp_region,
                              input tx_pkg::tx_stat_t exp);
    if (got_region != exp_region || got !== exp) begin
      flag_mismatch($sformatf("%s region %0d word %h, expected region %0d word %h",
                              what, got_region, got, exp_region, exp));
    end
  endtask

  task automatic compare_region(input string what,
                                input logic [tx_pkg::region_bits-1:0] got,
                                input logic [tx_pkg::region_bits-1:0] exp);
    if (got !== exp) begin
      flag_mismatch($sformatf("%s region %0d, expected %0d", what, got, exp));
    end
  endtask

  task automatic compare_count(input string what, input int got, input int exp);
    if (got != exp) begin
      flag_mismatch($sformatf("%s %0d, expected %0d", what, got, exp));
    end
  endtask

  // --------------------
  // Monitor
  // --------------------

  // Next output beat against the request order and region payload
  task automatic check_out_beat();
    rec_t  e;
    beat_t exp_b;
    beats_due--;
    if (cur_left == 0) begin
      if (sb_q.size() == 0) begin
        report_error("output beat appeared with no forwarded request on record");
        return;
      end
      e          = sb_q.pop_front();
      cur_region = e.region;
      // Byte length rounded up to whole beats
      cur_left   = (int'(e.meta.len) + 7) / 8;
    end
    cur_left--;
    if (sent_q[cur_region].size() == 0) begin
      report_error($sformatf("output beat before region %0d sent its payload", cur_region));
      return;
    end
    exp_b = sent_q[cur_region].pop_front();
    compare_beat("output beat", m_axis_tdata, m_axis_tkeep, m_axis_tlast, exp_b);
  endtask

  // Transfer must close on its final counted beat
  task automatic confirm_mux_idle();
    if (dut_i.u_data_mux.state !== tx_pkg::mux_idle) begin
      report_error("payload mux still busy after the last expected beat");
    end
  endtask

  task automatic record_payload(input int r);
    beat_t b;
    b.data = s_axis_tdata[r];
    b.keep = s_axis_tkeep[r];
    b.last = s_axis_tlast[r];
    sent_q[r].push_back(b);
  endtask

  // Winner taken from the one ready bit
  task automatic record_meta();
    rec_t e;
    int   win;
    win = 0;
    for (int r = 0; r < n_reg; r++) begin
      if (s_meta_ready[r]) win = r;
    end
    if ($countones(s_meta_ready) != 1 || (s_meta_ready & ~s_meta_valid) != '0) begin
      report_error("request forwarded without exactly one requesting region made ready");
      return;
    end
    compare_meta("forwarded request", m_meta_data, s_meta_data[win]);
    e.region = tx_pkg::region_bits'(win);
    e.meta   = s_meta_data[win];
    sb_q.push_back(e);
    own_q.push_back(e);
    grant_log.push_back(e.region);
    meta_log.push_back(m_meta_data);
  endtask

  // Handshakes taken at the rising edge
  always @(posedge aclk) begin : monitor
    if (aresetn) begin
      if (m_axis_tvalid && m_axis_tready) check_out_beat();
      for (int r = 0; r < n_reg; r++) begin
        if (s_axis_tvalid[r] && s_axis_tready[r]) record_payload(r);
      end
      if (m_meta_valid && m_meta_ready) record_meta();
    end
  end

  // --------------------
  // Drivers
  // --------------------

  task automatic apply_reset();
    @(negedge aclk);
    aresetn = 1'b0;
    repeat (4) @(negedge aclk);
    aresetn = 1'b1;
  endtask

  // Queue one request and its payload beats
  // Partial keep and tlast go on the final beat
  task automatic add_packet(input int r, input logic [tx_pkg::sid_bits-1:0] sid,
                            input int len);
    tx_pkg::tx_meta_t m;
    beat_t            b;
    int               n;
    n     = (len + 7) / 8;
    m.sid = sid;
    m.len = tx_pkg::len_bits'(len);
    req_q[r].push_back(m);
    for (int i = 0; i < n; i++) begin
      b.data = {8'(r), sid[7:0], 16'(i), $urandom()};
      b.keep = '1;
      if (i == n - 1 && len % 8 != 0) begin
        b.keep = net_pkg::keep_bits'((1 << (len % 8)) - 1);
      end
      b.last = (i == n - 1);
      pay_q[r].push_back(b);
    end
    beats_due += n;
  endtask

  function automatic bit work_left();
    for (int r = 0; r < n_reg; r++) begin
      if (req_q[r].size() > 0 || pay_q[r].size() > 0) return 1'b1;
    end
    return beats_due > 0;
  endfunction

  // All regions driven at once until every beat is out
  // Reverse mode feeds only the highest region with payload left
  task automatic run_traffic(input bit pay_reverse, input bit ready_random);
    int pick;
    while (work_left()) begin
      @(negedge aclk);
      pick = -1;
      for (int r = 0; r < n_reg; r++) begin
        if (pay_q[r].size() > 0) pick = r;
      end
      for (int r = 0; r < n_reg; r++) begin
        s_meta_valid[r] = (req_q[r].size() > 0);
        if (s_meta_valid[r]) s_meta_data[r] = req_q[r][0];
        s_axis_tvalid[r] = (pay_q[r].size() > 0) && (!pay_reverse || r == pick);
        if (s_axis_tvalid[r]) begin
          {s_axis_tdata[r], s_axis_tkeep[r], s_axis_tlast[r]} = pay_q[r][0];
        end
      end
      m_axis_tready = ready_random ? ($urandom % 2 == 0) : 1'b1;
      @(posedge aclk);
      for (int r = 0; r < n_reg; r++) begin
        if (s_meta_valid[r] && s_meta_ready[r]) void'(req_q[r].pop_front());
        if (s_axis_tvalid[r] && s_axis_tready[r]) void'(pay_q[r].pop_front());
      end
    end
    @(negedge aclk);
    s_meta_valid  = '0;
    s_axis_tvalid = '0;
    m_axis_tready = 1'b1;
    confirm_mux_idle();
  endtask

  // One status word per forwarded request in request order
  task automatic return_status(input bit stall);
    rec_t             e;
    tx_pkg::tx_stat_t word;
    logic [n_reg-1:0] owner_bit;
    logic [n_reg-1:0] taken;
    int               got_r;
    bit               done;
    while (own_q.size() > 0) begin
      e         = own_q.pop_front();
      word.sid  = e.meta.sid;
      word.len  = e.meta.len;
      word.err  = ($urandom % 2 == 0);
      owner_bit = '0;
      owner_bit[e.region] = 1'b1;
      done = 1'b0;
      while (!done) begin
        @(negedge aclk);
        s_stat_valid = 1'b1;
        s_stat_data  = word;
        m_stat_ready = stall ? n_reg'($urandom) : '1;
        @(posedge aclk);
        if (m_stat_valid != owner_bit) begin
          report_error($sformatf("status valid shown at regions %b, owner is region %0d",
                                 m_stat_valid, e.region));
        end
        if (s_stat_ready) begin
          taken = m_stat_valid & m_stat_ready;
          got_r = -1;
          for (int r = 0; r < n_reg; r++) begin
            if (taken[r]) got_r = r;
          end
          compare_stat("routed status", got_r, m_stat_data, e.region, word);
          stats_seen++;
          done = 1'b1;
        end
      end
    end
    @(negedge aclk);
    s_stat_valid = 1'b0;
    m_stat_ready = '1;
  endtask

  task automatic begin_test();
    test_err0  = errors;
    stats_seen = 0;
    grant_log.delete();
    meta_log.delete();
  endtask

  task automatic end_test(input string name);
    if (errors == test_err0) begin
      n_pass++;
      $display("[%0t ns] %s: ok", $time, name);
    end else begin
      n_fail++;
      $display("[%0t ns] %s: FAILED with %0d errors", $time, name, errors - test_err0);
    end
  endtask

  // --------------------
  // Tests
  // --------------------

  task automatic single_request();
    tx_pkg::tx_meta_t req;
    begin_test();
    req.sid = 16'h0a02;
    req.len = 16'd24;
    add_packet(2, req.sid, 24);
    run_traffic(1'b0, 1'b0);
    return_status(1'b0);
    compare_count("requests forwarded", grant_log.size(), 1);
    if (grant_log.size() > 0) begin
      compare_meta("request at engine", meta_log[0], req);
      compare_region("winner", grant_log[0], 2'd2);
    end
    end_test("single request from region 2");
  endtask

  // Pointer back at region 0 first
  task automatic round_robin_order();
    apply_reset();
    begin_test();
    for (int k = 0; k < 2; k++) begin
      for (int r = 0; r < n_reg; r++) begin
        add_packet(r, 16'h0b00 + 16'(4 * k + r), 16);
      end
    end
    run_traffic(1'b0, 1'b0);
    return_status(1'b0);
    compare_count("requests forwarded", grant_log.size(), 8);
    for (int k = 0; k < grant_log.size(); k++) begin
      compare_region("grant order", grant_log[k], tx_pkg::region_bits'(k % n_reg));
    end
    end_test("round robin from reset");
  endtask

  // Region 3 payload lands first and region 0 last
  task automatic reverse_payload();
    begin_test();
    add_packet(0, 16'h0c00, 24);
    add_packet(1, 16'h0c01, 16);
    add_packet(2, 16'h0c02, 40);
    add_packet(3, 16'h0c03, 8);
    run_traffic(1'b1, 1'b0);
    return_status(1'b0);
    compare_count("requests forwarded", grant_log.size(), 4);
    for (int k = 0; k < grant_log.size(); k++) begin
      compare_region("grant order", grant_log[k], tx_pkg::region_bits'(k));
    end
    end_test("payload in reverse region order");
  endtask

  task automatic odd_lengths();
    begin_test();
    add_packet(1, 16'h0d01, 1);
    add_packet(1, 16'h0d02, 9);
    add_packet(1, 16'h0d03, 63);
    add_packet(3, 16'h0d04, 8);
    add_packet(0, 16'h0d05, 65);
    run_traffic(1'b0, 1'b0);
    return_status(1'b0);
    compare_count("requests forwarded", grant_log.size(), 5);
    end_test("lengths off the beat size");
  endtask

  task automatic random_backpressure();
    int len;
    begin_test();
    for (int k = 0; k < 6; k++) begin
      len = 1 + int'($urandom % 96);
      add_packet(int'($urandom % n_reg), 16'h0e00 + 16'(k), len);
    end
    run_traffic(1'b0, 1'b1);
    return_status(1'b0);
    compare_count("requests forwarded", grant_log.size(), 6);
    end_test("random output back-pressure");
  endtask

  // Owners stall at random while their word waits
  task automatic status_routing();
    begin_test();
    add_packet(3, 16'h0f00, 8);
    add_packet(1, 16'h0f01, 16);
    add_packet(1, 16'h0f02, 24);
    add_packet(0, 16'h0f03, 32);
    add_packet(2, 16'h0f04, 40);
    add_packet(3, 16'h0f05, 48);
    run_traffic(1'b0, 1'b0);
    return_status(1'b1);
    compare_count("status words routed", stats_seen, 6);
    end_test("status routing with stalled regions");
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    void'($urandom(46));
    errors        = 0;
    n_pass        = 0;
    n_fail        = 0;
    beats_due     = 0;
    cur_left      = 0;
    cur_region    = 0;
    aresetn       = 1'b0;
    s_meta_valid  = '0;
    m_meta_ready  = 1'b1;
    s_axis_tvalid = '0;
    s_axis_tlast  = '0;
    m_axis_tready = 1'b1;
    s_stat_valid  = 1'b0;
    s_stat_data   = '0;
    m_stat_ready  = '1;
    for (int r = 0; r < n_reg; r++) begin
      s_meta_data[r]  = '0;
      s_axis_tdata[r] = '0;
      s_axis_tkeep[r] = '0;
    end
    apply_reset();
    if (m_meta_valid || m_axis_tvalid || s_meta_ready != '0 || m_stat_valid != '0 ||
        s_stat_ready) begin
      report_error("outputs not idle after reset");
    end
    single_request();
    round_robin_order();
    reverse_payload();
    odd_lengths();
    random_backpressure();
    status_routing();
    $display("tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, errors);
    if (n_fail == 0 && errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
